// File: project.f
src/conv_pkg.sv
src/feature_mem.sv
src/mem_arbiter.sv
src/conv3x3.sv
src/conv_module.sv
src/tile_loader.sv
src/axi_lite_slave.sv
src/conv_accel_top.sv
tb/tb_conv_accel.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_conv_accel
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/tb_conv_accel.sv
`timescale 1ns/1ps
`default_nettype none

module tb_conv_accel;
    import conv_pkg::*;

    localparam int TIMEOUT    = 200; // cycles per handshake
    localparam int POLL_LIMIT = 400;

    logic        clk;
    logic        rst_n;
    logic [11:0] awaddr, araddr;
    logic        awvalid, awready, wvalid, wready;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    logic        bvalid, bready, arvalid, arready, rvalid, rready;

    logic [31:0] lfsr;
    int          err_count, check_count, test_errs, test_checks;
    string       cur_test;
    logic [7:0]  img [64];
    logic [7:0]  wgt [28]; // byte 27 pads the last weight word
    logic [31:0] exp_out [27];

    conv_accel_top dut (.*);

    always #20 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic rand_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < 32; i++) begin
            r = {r[30:0], rand_bit()};
        end
        return r;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < 8; i++) begin
            r = {r[6:0], rand_bit()};
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("[ERROR] %s %s: expected %08h, actual %08h", cur_test, name, exp, act);
        end
    endtask

    task automatic report_timeout(input string what);
        err_count++;
        $display("timeout: %s did not arrive in time", what);
    endtask

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        int n;
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        n = 0;
        while (n < TIMEOUT) begin
            @(posedge clk);
            if (awready) break;
            n++;
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        if (n == TIMEOUT) begin
            report_timeout("awready");
            return;
        end
        n = 0;
        while (n < TIMEOUT) begin
            bready <= rand_bit(); // random back-pressure on B
            @(posedge clk);
            if (bvalid && bready) break;
            n++;
        end
        bready <= 1'b0;
        if (n == TIMEOUT) report_timeout("bvalid");
        else check("bresp", 32'h0, 32'(bresp));
    endtask

    task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
        int n;
        data    = 'x;
        araddr  <= addr;
        arvalid <= 1'b1;
        n = 0;
        while (n < TIMEOUT) begin
            @(posedge clk);
            if (arready) break;
            n++;
        end
        arvalid <= 1'b0;
        if (n == TIMEOUT) begin
            report_timeout("arready");
            return;
        end
        n = 0;
        while (n < TIMEOUT) begin
            rready <= rand_bit();
            @(posedge clk);
            if (rvalid && rready) break;
            n++;
        end
        rready <= 1'b0;
        if (n == TIMEOUT) begin
            report_timeout("rvalid");
            return;
        end
        data = rdata;
        check("rresp", 32'h0, 32'(rresp));
    endtask

    function automatic logic [31:0] img_word(input int i);
        return {img[4*i+3], img[4*i+2], img[4*i+1], img[4*i]};
    endfunction

    task automatic load_inputs();
        for (int i = 0; i < 16; i++) begin
            axi_write(12'((IMG_BASE + i) * 4), img_word(i), 4'hf);
        end
        for (int j = 0; j < 7; j++) begin
            axi_write(12'((WGT_BASE + j) * 4),
                      {wgt[4*j+3], wgt[4*j+2], wgt[4*j+1], wgt[4*j]}, 4'hf);
        end
    endtask

    // byte k*36+r*6+c is the nine-product sum of map k at (r,c), modulo 256
    task automatic compute_model();
        logic [7:0] res [108];
        int         sum;
        for (int k = 0; k < 3; k++) begin
            for (int r = 0; r < 6; r++) begin
                for (int c = 0; c < 6; c++) begin
                    sum = 0;
                    for (int t = 0; t < 9; t++) begin
                        sum += int'(img[(r + t / 3) * 8 + c + t % 3]) * int'(wgt[k * 9 + t]);
                    end
                    res[k * 36 + r * 6 + c] = 8'(sum);
                end
            end
        end
        for (int i = 0; i < 27; i++) begin
            exp_out[i] = {res[4*i+3], res[4*i+2], res[4*i+1], res[4*i]};
        end
    endtask

    task automatic run_conv(input bit interleave);
        logic [31:0] data, img_rd;
        int          polls;
        compute_model();
        axi_write(CTRL_ADDR, 32'h1, 4'h1);
        axi_read(CTRL_ADDR, data);
        check("done clear", 32'h0, 32'(data[1]));
        polls = 0;
        while (data[1] !== 1'b1 && polls < POLL_LIMIT) begin
            if (interleave) begin
                axi_read(12'((IMG_BASE + polls % 16) * 4), img_rd);
                check($sformatf("image word %0d", polls % 16),
                      img_word(polls % 16), img_rd);
            end
            axi_read(CTRL_ADDR, data);
            polls++;
        end
        if (data[1] !== 1'b1) begin
            report_timeout("done");
            return;
        end
        for (int i = 0; i < 27; i++) begin
            axi_read(12'((OUT_BASE + i) * 4), data);
            check($sformatf("result word %0d", i), exp_out[i], data);
        end
    endtask

    task automatic mark_test_start(input string name);
        cur_test    = name;
        test_errs   = err_count;
        test_checks = check_count;
    endtask

    task automatic print_test_result();
        $display("%s: %0d checks, %0d errors", cur_test,
                 check_count - test_checks, err_count - test_errs);
    endtask

    task automatic readback_test();
        logic [31:0] words [23];
        logic [31:0] data;
        for (int i = 0; i < 23; i++) begin
            words[i] = rand_word();
            axi_write(12'(i * 4), words[i], 4'hf);
        end
        for (int i = 0; i < 23; i++) begin
            axi_read(12'(i * 4), data);
            check($sformatf("readback word %0d", i), words[i], data);
        end
    endtask

    task automatic randomize_inputs();
        for (int i = 0; i < 64; i++) begin
            img[i] = rand_byte();
        end
        for (int i = 0; i < 28; i++) begin
            wgt[i] = rand_byte();
        end
    endtask

    initial begin
        logic [31:0] data;
        clk     = 1'b0;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        lfsr    = 32'h4b02b53b;
        err_count   = 0;
        check_count = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        mark_test_start("reset_ctrl");
        axi_read(CTRL_ADDR, data);
        check("ctrl", 32'h0, data);
        print_test_result();

        mark_test_start("readback");
        readback_test();
        print_test_result();

        mark_test_start("random_conv");
        randomize_inputs();
        load_inputs();
        run_conv(1'b0);
        print_test_result();

        mark_test_start("wraparound");
        for (int i = 0; i < 64; i++) img[i] = 8'hff;
        for (int i = 0; i < 28; i++) wgt[i] = 8'hff;
        load_inputs();
        run_conv(1'b0); // nine times 255*255 wraps
        print_test_result();

        mark_test_start("contention");
        randomize_inputs();
        load_inputs();
        run_conv(1'b1);
        print_test_result();

        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/conv_accel_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_accel_top (
    input  logic                clk,
    input  logic                rst_n,
    input  conv_pkg::axi_addr_t awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  conv_pkg::word_t     wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  conv_pkg::axi_addr_t araddr,
    input  logic                arvalid,
    output logic                arready,
    output conv_pkg::word_t     rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready
);
    import conv_pkg::*;

    logic                host_req, host_we, host_gnt;
    waddr_t              host_addr;
    word_t               host_wdata, host_rdata;
    logic [3:0]          host_be;
    logic                ldr_req, ldr_we, ldr_gnt;
    waddr_t              ldr_addr;
    word_t               ldr_wdata, ldr_rdata;
    logic                mem_we;
    waddr_t              mem_addr;
    word_t               mem_wdata, mem_rdata;
    logic [3:0]          mem_be;
    logic                start, done;
    logic                in_vld, out_vld;
    logic [IMG_BITS-1:0] data_lin;
    logic [WGT_BITS-1:0] weight_lin;
    logic [OUT_BITS-1:0] conv_lin;

    // AXI ports, start and done connect by name
    axi_lite_slave u_axi_lite_slave (
        .mem_req   (host_req),
        .mem_we    (host_we),
        .mem_addr  (host_addr),
        .mem_wdata (host_wdata),
        .mem_be    (host_be),
        .mem_gnt   (host_gnt),
        .mem_rdata (host_rdata),
        .*
    );

    tile_loader u_tile_loader (
        .req   (ldr_req),
        .we    (ldr_we),
        .addr  (ldr_addr),
        .wdata (ldr_wdata),
        .gnt   (ldr_gnt),
        .rdata (ldr_rdata),
        .*
    );

    conv_module u_conv_module (.*);

    mem_arbiter u_mem_arbiter (.*);

    feature_mem u_feature_mem (
        .clk   (clk),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .be    (mem_be),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: src/axi_lite_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_slave (
    input  logic                clk,
    input  logic                rst_n,
    input  conv_pkg::axi_addr_t awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  conv_pkg::word_t     wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  conv_pkg::axi_addr_t araddr,
    input  logic                arvalid,
    output logic                arready,
    output conv_pkg::word_t     rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,
    output logic                mem_req,
    output logic                mem_we,
    output conv_pkg::waddr_t    mem_addr,
    output conv_pkg::word_t     mem_wdata,
    output logic [3:0]          mem_be,
    input  logic                mem_gnt,
    input  conv_pkg::word_t     mem_rdata,
    output logic                start,
    input  logic                done
);
    import conv_pkg::*;

    axi_state_e state;

    assign awready = (state == AX_IDLE) && awvalid && wvalid;
    assign wready  = awready;
    assign arready = (state == AX_IDLE) && arvalid && !(awvalid && wvalid); // writes first
    assign bresp   = 2'b00;
    assign rresp   = 2'b00;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= AX_IDLE;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            mem_req <= 1'b0;
            start   <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                AX_IDLE: begin
                    if (awready) begin
                        if (awaddr >= CTRL_ADDR) begin
                            start  <= wstrb[0] & wdata[0];
                            bvalid <= 1'b1;
                            state  <= AX_RESP;
                        end else begin
                            mem_req <= 1'b1;
                            state   <= AX_MEM_WAIT;
                        end
                    end else if (arready) begin
                        if (araddr >= CTRL_ADDR) begin
                            rvalid <= 1'b1;
                            state  <= AX_RESP;
                        end else begin
                            mem_req <= 1'b1;
                            state   <= AX_MEM_WAIT;
                        end
                    end
                end
                AX_MEM_WAIT: begin
                    if (mem_req && mem_gnt) begin
                        mem_req <= 1'b0;
                        if (mem_we) begin
                            bvalid <= 1'b1;
                            state  <= AX_RESP;
                        end
                    end else if (!mem_req) begin
                        rvalid <= 1'b1; // read data lands this cycle
                        state  <= AX_RESP;
                    end
                end
                AX_RESP: begin
                    if ((bvalid && bready) || (rvalid && rready)) begin
                        bvalid <= 1'b0;
                        rvalid <= 1'b0;
                        state  <= AX_IDLE;
                    end
                end
                default: state <= AX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (awready) begin
            mem_we    <= 1'b1;
            mem_addr  <= awaddr[$bits(waddr_t)+1:2];
            mem_wdata <= wdata;
            mem_be    <= wstrb;
        end else if (arready) begin
            mem_we   <= 1'b0;
            mem_addr <= araddr[$bits(waddr_t)+1:2];
            rdata    <= word_t'({done, 1'b0}); // control register view
        end
        if (state == AX_MEM_WAIT && !mem_req) rdata <= mem_rdata;
    end

    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

endmodule

`default_nettype wire

// File: src/tile_loader.sv
`timescale 1ns/1ps
`default_nettype none

module tile_loader (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    output logic                          done,
    output logic                          req,
    output logic                          we,
    output conv_pkg::waddr_t              addr,
    output conv_pkg::word_t               wdata,
    input  logic                          gnt,
    input  conv_pkg::word_t               rdata,
    output logic                          in_vld,
    output logic [conv_pkg::IMG_BITS-1:0] data_lin,
    output logic [conv_pkg::WGT_BITS-1:0] weight_lin,
    input  logic [conv_pkg::OUT_BITS-1:0] conv_lin,
    input  logic                          out_vld
);
    import conv_pkg::*;

    loader_state_e state;
    logic [4:0]    word_cnt;
    logic          rd_pend; // read granted, data due this cycle
    logic [(WGT_BASE + WGT_WORDS - IMG_BASE) * 32 - 1:0] ld_buf;

    assign req   = (state == LD_LOAD && !rd_pend) || state == LD_STORE;
    assign we    = (state == LD_STORE);
    assign addr  = waddr_t'((state == LD_STORE ? OUT_BASE : IMG_BASE) + word_cnt);
    assign wdata = conv_lin[word_cnt * 32 +: 32];

    // image and weight words sit back to back, word 0 ends up at the bottom
    assign data_lin   = ld_buf[IMG_BITS-1:0];
    assign weight_lin = ld_buf[IMG_WORDS * 32 +: WGT_BITS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= LD_IDLE;
            word_cnt <= '0;
            rd_pend  <= 1'b0;
            done     <= 1'b0;
            in_vld   <= 1'b0;
        end else begin
            case (state)
                LD_IDLE: begin
                    if (start) begin
                        done     <= 1'b0;
                        word_cnt <= '0;
                        state    <= LD_LOAD;
                    end
                end
                LD_LOAD: begin
                    if (rd_pend) begin
                        rd_pend <= 1'b0;
                        if (word_cnt == 5'(WGT_BASE + WGT_WORDS - 1)) begin
                            word_cnt <= '0;
                            in_vld   <= 1'b1;
                            state    <= LD_CONV;
                        end else begin
                            word_cnt <= word_cnt + 5'd1;
                        end
                    end else if (gnt) begin
                        rd_pend <= 1'b1;
                    end
                end
                LD_CONV: begin
                    if (out_vld) begin
                        in_vld <= 1'b0;
                        state  <= LD_STORE;
                    end
                end
                LD_STORE: begin
                    if (gnt) begin
                        if (word_cnt == 5'(OUT_WORDS - 1)) begin
                            state <= LD_FINISH;
                        end else begin
                            word_cnt <= word_cnt + 5'd1;
                        end
                    end
                end
                LD_FINISH: begin
                    done  <= 1'b1;
                    state <= LD_IDLE;
                end
                default: state <= LD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pend) ld_buf <= {rdata, ld_buf[$bits(ld_buf)-1:32]};
    end

endmodule

`default_nettype wire

// File: src/conv_module.sv
`timescale 1ns/1ps
`default_nettype none

module conv_module (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_vld,
    input  logic [conv_pkg::IMG_BITS-1:0] data_lin,
    input  logic [conv_pkg::WGT_BITS-1:0] weight_lin,
    output logic [conv_pkg::OUT_BITS-1:0] conv_lin,
    output logic                          out_vld
);
    import conv_pkg::*;

    logic [2:0]       r_cnt, c_cnt;
    logic [5:0]       base; // top-left pixel of the window
    logic [N_KER-1:0] win_vld;
    pix_t             win [TAPS];
    pix_t             ans [N_KER];
    logic             last_pos;

    assign base     = 6'(r_cnt * IMG_DIM + c_cnt);
    assign last_pos = (r_cnt == 3'(OUT_DIM - 1)) && (c_cnt == 3'(OUT_DIM - 1));

    always_comb begin
        for (int t = 0; t < TAPS; t++) begin
            win[t] = data_lin[(base + (t / KER_DIM) * IMG_DIM + t % KER_DIM) * 8 +: 8];
        end
    end

    for (genvar k = 0; k < N_KER; k++) begin : g_ker
        conv3x3 u_conv3x3 (
            .clk     (clk),
            .rst_n   (rst_n),
            .in_vld  (in_vld),
            .data0   (win[0]),
            .data1   (win[1]),
            .data2   (win[2]),
            .data3   (win[3]),
            .data4   (win[4]),
            .data5   (win[5]),
            .data6   (win[6]),
            .data7   (win[7]),
            .data8   (win[8]),
            .weight0 (weight_lin[(k * TAPS + 0) * 8 +: 8]),
            .weight1 (weight_lin[(k * TAPS + 1) * 8 +: 8]),
            .weight2 (weight_lin[(k * TAPS + 2) * 8 +: 8]),
            .weight3 (weight_lin[(k * TAPS + 3) * 8 +: 8]),
            .weight4 (weight_lin[(k * TAPS + 4) * 8 +: 8]),
            .weight5 (weight_lin[(k * TAPS + 5) * 8 +: 8]),
            .weight6 (weight_lin[(k * TAPS + 6) * 8 +: 8]),
            .weight7 (weight_lin[(k * TAPS + 7) * 8 +: 8]),
            .weight8 (weight_lin[(k * TAPS + 8) * 8 +: 8]),
            .ans     (ans[k]),
            .out_vld (win_vld[k])
        );
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_cnt <= '0;
            c_cnt <= '0;
        end else if (!in_vld) begin
            r_cnt <= '0;
            c_cnt <= '0;
        end else if (win_vld[0]) begin
            if (c_cnt == 3'(OUT_DIM - 1)) begin
                c_cnt <= '0;
                r_cnt <= last_pos ? 3'd0 : r_cnt + 3'd1;
            end else begin
                c_cnt <= c_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vld <= 1'b0;
        end else if (!in_vld) begin
            out_vld <= 1'b0;
        end else if (win_vld[0] && last_pos) begin
            out_vld <= 1'b1; // held until the loader drops in_vld
        end
    end

    always_ff @(posedge clk) begin
        if (win_vld[0]) begin
            for (int k = 0; k < N_KER; k++) begin
                conv_lin[(k * OUT_DIM * OUT_DIM + r_cnt * OUT_DIM + c_cnt) * 8 +: 8] <= ans[k];
            end
        end
    end

    a_units_agree: assert property (@(posedge clk) disable iff (!rst_n)
        (&win_vld) == (|win_vld))
        else $error("conv3x3 window pulses disagree");

endmodule

`default_nettype wire

// File: src/conv3x3.sv
`timescale 1ns/1ps
`default_nettype none

module conv3x3 (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_vld,
    input  conv_pkg::pix_t data0, data1, data2, data3, data4, data5, data6, data7, data8,
    input  conv_pkg::pix_t weight0, weight1, weight2, weight3, weight4,
    input  conv_pkg::pix_t weight5, weight6, weight7, weight8,
    output conv_pkg::pix_t ans,
    output logic           out_vld
);
    import conv_pkg::*;

    logic [3:0]  tap;
    pix_t        d [TAPS];
    pix_t        w [TAPS];
    logic [15:0] prod;
    acc_t        acc, sum;

    assign d = '{data0, data1, data2, data3, data4, data5, data6, data7, data8};
    assign w = '{weight0, weight1, weight2, weight3, weight4, weight5, weight6, weight7, weight8};

    assign prod    = 16'(d[tap]) * 16'(w[tap]);
    assign sum     = acc + acc_t'(prod);
    assign ans     = pix_t'(sum); // modulo 256
    assign out_vld = in_vld && (tap == 4'(TAPS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tap <= '0;
        end else if (!in_vld || tap == 4'(TAPS - 1)) begin
            tap <= '0;
        end else begin
            tap <= tap + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        acc <= (tap == '0) ? acc_t'(prod) : sum; // tap 0 starts a new window
    end

    a_tap_range: assert property (@(posedge clk) disable iff (!rst_n)
        tap <= 4'(TAPS - 1))
        else $error("tap counter ran past the last tap");

endmodule

`default_nettype wire

// File: src/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             host_req,
    input  logic             host_we,
    input  conv_pkg::waddr_t host_addr,
    input  conv_pkg::word_t  host_wdata,
    input  logic [3:0]       host_be,
    output logic             host_gnt,
    output conv_pkg::word_t  host_rdata,
    input  logic             ldr_req,
    input  logic             ldr_we,
    input  conv_pkg::waddr_t ldr_addr,
    input  conv_pkg::word_t  ldr_wdata,
    output logic             ldr_gnt,
    output conv_pkg::word_t  ldr_rdata,
    output logic             mem_we,
    output conv_pkg::waddr_t mem_addr,
    output conv_pkg::word_t  mem_wdata,
    output logic [3:0]       mem_be,
    input  conv_pkg::word_t  mem_rdata
);
    import conv_pkg::*;

    logic  host_rd_q, ldr_rd_q; // whose read returns this cycle
    word_t host_hold, ldr_hold;

    assign host_gnt  = host_req;
    assign ldr_gnt   = ldr_req && !host_req;
    assign mem_we    = host_gnt ? host_we : (ldr_gnt && ldr_we);
    assign mem_addr  = host_gnt ? host_addr : ldr_addr;
    assign mem_wdata = host_gnt ? host_wdata : ldr_wdata;
    assign mem_be    = host_gnt ? host_be : 4'hf; // loader writes whole words

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            host_rd_q <= 1'b0;
            ldr_rd_q  <= 1'b0;
        end else begin
            host_rd_q <= host_gnt && !host_we;
            ldr_rd_q  <= ldr_gnt && !ldr_we;
        end
    end

    assign host_rdata = host_rd_q ? mem_rdata : host_hold;
    assign ldr_rdata  = ldr_rd_q ? mem_rdata : ldr_hold;

    always_ff @(posedge clk) begin
        host_hold <= host_rdata;
        ldr_hold  <= ldr_rdata;
    end

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({host_gnt, ldr_gnt}) && !(host_rd_q && ldr_rd_q))
        else $error("memory granted to both peers");

endmodule

`default_nettype wire

// File: src/feature_mem.sv
`timescale 1ns/1ps
`default_nettype none

module feature_mem (
    input  logic             clk,
    input  logic             we,
    input  conv_pkg::waddr_t addr,
    input  conv_pkg::word_t  wdata,
    input  logic [3:0]       be,
    output conv_pkg::word_t  rdata
);
    import conv_pkg::*;

    word_t mem [2**$bits(waddr_t)];

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
        rdata <= mem[addr]; // old data on a write cycle
    end

endmodule

`default_nettype wire

// File: src/conv_pkg.sv
`default_nettype none

package conv_pkg;

    typedef logic [7:0]  pix_t;
    typedef logic [19:0] acc_t;     // nine full 16-bit products
    typedef logic [31:0] word_t;
    typedef logic [5:0]  waddr_t;
    typedef logic [11:0] axi_addr_t; // host byte address

    localparam int IMG_DIM = 8;
    localparam int KER_DIM = 3;
    localparam int OUT_DIM = 6;
    localparam int N_KER   = 3;
    localparam int TAPS    = 9;

    localparam int IMG_BITS = 512;
    localparam int WGT_BITS = 216;
    localparam int OUT_BITS = 864;

    localparam int IMG_BASE  = 0;
    localparam int IMG_WORDS = 16;
    localparam int WGT_BASE  = 16;
    localparam int WGT_WORDS = 7;  // last word padded
    localparam int OUT_BASE  = 32;
    localparam int OUT_WORDS = 27;

    localparam axi_addr_t CTRL_ADDR = 12'h100; // bit 0 start, bit 1 done

    typedef enum logic [2:0] {
        LD_IDLE,
        LD_LOAD,
        LD_CONV,
        LD_STORE,
        LD_FINISH
    } loader_state_e;

    typedef enum logic [1:0] {
        AX_IDLE,
        AX_MEM_WAIT,
        AX_RESP
    } axi_state_e;

endpackage

`default_nettype wire
